// ==== flist.f ====
+incdir+include
source/opq_pkg.sv
source/opq_feed_if.sv
source/opq_fifo.sv
source/opq_operand_buffer.sv
source/opq_widen_unit.sv
source/opq_output_ctrl.sv
source/operand_queue_top.sv
sim/tb_clk_gen.sv
sim/tb_operand_queue.sv

// ==== include/opq_settings.svh ====
// Operand queue build settings: word width, buffer depths, consumer count, count width

`ifndef OPQ_SETTINGS_SVH
`define OPQ_SETTINGS_SVH

// Operand word width in bits
`define OPQ_DATA_W 64

// Command FIFO depth
`define OPQ_CMD_DEPTH 2

// Operand FIFO depth and read credit limit
`define OPQ_DATA_DEPTH 2

// Number of consumer ready bits
`define OPQ_NR_CONSUMERS 2

// Width of the per-command element count
`define OPQ_ELEM_CNT_W 8

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the operand queue testbench with Verilator, run it, and check the result

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_opq

verilator --binary --timing --timescale 1ns/1ns \
  -f flist.f --top-module tb_operand_queue \
  --Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$("./$BUILD_DIR/$SIM_BIN")
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Regression passed"; then
  exit 0
fi
exit 1

// ==== sim/tb_clk_gen.sv ====
// Testbench clock generator and power-on reset
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS    = 8,
  parameter int unsigned RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release just after an edge, like any other driven input
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

// ==== sim/tb_operand_queue.sv ====
// Operand queue testbench with random stimulus, reference model, checks and flush test
`timescale 1ns/1ns
`include "opq_settings.svh"

module tb_operand_queue import opq_pkg::*; ();

  localparam int NC           = `OPQ_NR_CONSUMERS;
  localparam int W            = `OPQ_DATA_W;
  localparam int RESET_CYCLES = 10;
  localparam int TIMEOUT      = 20000;

  logic          clk;
  logic          rst_n;
  logic          flush;
  opq_conv_e     cmd_conv;
  opq_eew_e      cmd_eew;
  opq_elem_cnt_t cmd_elem_count;
  opq_target_e   cmd_target;
  logic          cmd_valid;
  logic          cmd_ready;
  opq_word_t     operand_in;
  logic          operand_valid_in;
  logic          operand_issued;
  logic          queue_ready;
  opq_word_t     operand_out;
  opq_target_e   target_out;
  logic          valid_out;
  logic [NC-1:0] ready;

  // Stimulus and model state
  integer      seed;
  int          cyc, errors, credit, slot, count;
  int          words_to_issue, cmds_left, stall_left, last_due;
  bit          issue_en, ready_en, use_fixed, flush_req, cmd_taken;
  opq_cmd_t    fixed_cmd;
  opq_cmd_t    cmd_q[$];
  opq_word_t   word_q[$];
  int          due_q[$];

  tb_clk_gen #(.PERIOD_NS(8), .RESET_CYCLES(RESET_CYCLES)) i_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  operand_queue_top DUT (
    .clk_i                 (clk),
    .rst_ni                (rst_n),
    .flush_i               (flush),
    .cmd_conv_i            (cmd_conv),
    .cmd_eew_i             (cmd_eew),
    .cmd_elem_count_i      (cmd_elem_count),
    .cmd_target_i          (cmd_target),
    .cmd_valid_i           (cmd_valid),
    .cmd_ready_o           (cmd_ready),
    .operand_i             (operand_in),
    .operand_valid_i       (operand_valid_in),
    .operand_issued_i      (operand_issued),
    .operand_queue_ready_o (queue_ready),
    .operand_o             (operand_out),
    .operand_target_o      (target_out),
    .operand_valid_o       (valid_out),
    .operand_ready_i       (ready)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers and reference model

  task automatic stop_on_error(string line);
    errors++;
    $display("%s", line);
    $display("Regression failed");
    $fatal(1, "Stopped at the first error");
  endtask

  function automatic string mismatch_line(string what, logic [63:0] got, logic [63:0] exp);
    return $sformatf("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
  endfunction

  function automatic int rand_below(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic int factor_of(opq_conv_e conv);
    case (conv)
      CONV_SEXT2, CONV_ZEXT2: return 2;
      CONV_SEXT4, CONV_ZEXT4: return 4;
      CONV_SEXT8, CONV_ZEXT8: return 8;
      default:                return 1;
    endcase
  endfunction

  function automatic logic [63:0] low_mask(int w);
    return (w >= 64) ? '1 : (64'd1 << w) - 64'd1;
  endfunction

  // Output element k is source element slot+k, extended to w*F bits
  function automatic opq_word_t expect_word(opq_word_t word, opq_cmd_t cmd, int s);
    int          w;
    int          ow;
    int          k;
    logic [63:0] elem;
    logic [63:0] res;
    w   = 8 << int'(cmd.eew);
    ow  = w * factor_of(cmd.conv);
    res = '0;
    if (ow == w) return word;
    for (k = 0; k < W / ow; k++) begin
      elem = (word >> ((s + k) * w)) & low_mask(w);
      if (cmd.conv inside {CONV_SEXT2, CONV_SEXT4, CONV_SEXT8} && elem[w-1])
        elem = elem | ~low_mask(w);
      res = res | ((elem & low_mask(ow)) << (k * ow));
    end
    return res;
  endfunction

  // Only legal pairs, where element width times factor stays within a word
  function automatic opq_cmd_t random_command();
    opq_cmd_t c;
    int       ew;
    int       flog;
    int       sgn;
    ew           = rand_below(4);
    flog         = rand_below(4 - ew);
    sgn          = rand_below(2);
    c.eew        = opq_eew_e'(2'(ew));
    c.conv       = (flog == 0) ? CONV_NONE : opq_conv_e'(3'(2 * flog - sgn));
    c.elem_count = opq_elem_cnt_t'(1 + rand_below(24));
    c.target     = opq_target_e'(1'(rand_below(2)));
    return c;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Per-cycle drive and check

  task automatic drive_inputs();
    opq_cmd_t c;
    int       due;
    if (cmd_taken) cmd_valid = 1'b0;
    cmd_taken = 1'b0;
    if (!cmd_valid && cmds_left > 0 && rand_below(4) != 0) begin
      c              = use_fixed ? fixed_cmd : random_command();
      cmd_conv       = c.conv;
      cmd_eew        = c.eew;
      cmd_elem_count = c.elem_count;
      cmd_target     = c.target;
      cmd_valid      = 1'b1;
    end
    // Register file returns data in issue order
    operand_valid_in = 1'b0;
    if (due_q.size() > 0 && due_q[0] == cyc) begin
      void'(due_q.pop_front());
      operand_valid_in = 1'b1;
      operand_in       = {$random(seed), $random(seed)};
    end
    operand_issued = 1'b0;
    if (issue_en && words_to_issue > 0 && queue_ready && rand_below(4) != 0) begin
      operand_issued = 1'b1;
      words_to_issue--;
      due = cyc + 1 + rand_below(3);
      if (due <= last_due) due = last_due + 1;
      due_q.push_back(due);
      last_due = due;
    end
    if (!ready_en) begin
      ready = '0;
    end else if (stall_left > 0) begin
      ready = '0;
      stall_left--;
    end else if (rand_below(6) == 0) begin
      ready      = '0;
      stall_left = rand_below(6);
    end else begin
      ready = NC'(1 + rand_below((1 << NC) - 1));
    end
    flush     = flush_req;
    flush_req = 1'b0;
  endtask

  // Checks run at the falling edge and the model then steps past the next rising edge
  task automatic check_outputs();
    bit       exp_valid;
    bit       transfer;
    bit       pop_word;
    opq_cmd_t head;
    opq_cmd_t c;
    int       w;
    int       n;
    exp_valid = (cmd_q.size() > 0) && (word_q.size() > 0);
    assert (valid_out === exp_valid)
      else stop_on_error(mismatch_line("operand_valid_o", 64'(valid_out), 64'(exp_valid)));
    assert (cmd_ready === (cmd_q.size() < `OPQ_CMD_DEPTH))
      else stop_on_error(mismatch_line("cmd_ready_o", 64'(cmd_ready),
                                       64'(cmd_q.size() < `OPQ_CMD_DEPTH)));
    assert (queue_ready === (credit < `OPQ_DATA_DEPTH))
      else stop_on_error(mismatch_line("operand_queue_ready_o", 64'(queue_ready),
                                       64'(credit < `OPQ_DATA_DEPTH)));
    if (exp_valid) begin
      head = cmd_q[0];
      assert (operand_out === expect_word(word_q[0], head, slot))
        else stop_on_error(mismatch_line("operand_o", operand_out,
                                         expect_word(word_q[0], head, slot)));
      assert (target_out === head.target)
        else stop_on_error(mismatch_line("operand_target_o", 64'(target_out),
                                         64'(head.target)));
    end

    transfer = exp_valid && (|ready);
    if (transfer) begin
      w        = 8 << int'(head.eew);
      n        = W / (w * factor_of(head.conv));
      slot     = slot + n;
      count    = count + n;
      pop_word = (head.conv == CONV_NONE);
      if (slot >= W / w) begin
        slot     = 0;
        pop_word = 1'b1;
      end
      // At command end the next command starts on a fresh word
      if (count >= int'(head.elem_count)) begin
        void'(cmd_q.pop_front());
        slot     = 0;
        count    = 0;
        pop_word = 1'b1;
      end
      if (pop_word) begin
        void'(word_q.pop_front());
        credit--;
      end
    end
    if (cmd_valid && cmd_ready) begin
      c.conv       = cmd_conv;
      c.eew        = cmd_eew;
      c.elem_count = cmd_elem_count;
      c.target     = cmd_target;
      cmd_q.push_back(c);
      cmds_left--;
      cmd_taken = 1'b1;
      w = 8 << int'(c.eew);
      words_to_issue += (int'(c.elem_count) + W / w - 1) / (W / w);
    end
    if (operand_issued) credit++;
    if (operand_valid_in) word_q.push_back(operand_in);
    if (flush) begin
      cmd_q.delete();
      word_q.delete();
      credit         = 0;
      slot           = 0;
      count          = 0;
      words_to_issue = 0;
    end
  endtask

  task automatic step();
    @(posedge clk);
    cyc++;
    #1;
    drive_inputs();
    @(negedge clk);
    check_outputs();
  endtask

  task automatic run_until_idle(string phase);
    int n;
    n = 0;
    while (cmds_left > 0 || cmd_valid || cmd_q.size() > 0 || word_q.size() > 0 ||
           words_to_issue > 0 || due_q.size() > 0) begin
      step();
      n++;
      if (n > TIMEOUT) stop_on_error($sformatf("Timeout: the %s phase never drained", phase));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin : p_main
    int n;
    seed             = 32'h799f;
    flush            = 1'b0;
    cmd_conv         = CONV_NONE;
    cmd_eew          = EW8;
    cmd_elem_count   = '0;
    cmd_target       = FU_ALU;
    cmd_valid        = 1'b0;
    operand_in       = '0;
    operand_valid_in = 1'b0;
    operand_issued   = 1'b0;
    ready            = '0;
    fixed_cmd        = '{conv: CONV_SEXT2, eew: EW8, elem_count: 8'd40, target: FU_MFPU};

    n = 0;
    while (rst_n !== 1'b1) begin
      @(posedge clk);
      n++;
      if (n > 4 * RESET_CYCLES) stop_on_error("Timeout: reset was never released");
    end
    @(negedge clk);
    assert (valid_out === 1'b0 && cmd_ready === 1'b1 && queue_ready === 1'b1)
      else stop_on_error(mismatch_line("state after reset",
                                       64'({valid_out, cmd_ready, queue_ready}),
                                       64'(3'b011)));

    // Random legal commands under back-pressure
    issue_en  = 1'b1;
    ready_en  = 1'b1;
    cmds_left = 150;
    run_until_idle("random");

    // Long command that is flushed once its first word has gone out
    use_fixed = 1'b1;
    cmds_left = 1;
    n = 0;
    while (count == 0) begin
      step();
      n++;
      if (n > TIMEOUT) stop_on_error("Timeout: the long command never started");
    end
    ready_en = 1'b0;
    issue_en = 1'b0;
    n = 0;
    while (due_q.size() > 0) begin
      step();
      n++;
      if (n > TIMEOUT) stop_on_error("Timeout: issued reads never returned");
    end
    flush_req = 1'b1;
    step();
    step();

    // The same widening command again, which must start from slot 0
    issue_en  = 1'b1;
    ready_en  = 1'b1;
    cmds_left = 1;
    run_until_idle("first post-flush");

    // Fresh random commands after the flush
    use_fixed = 1'b0;
    cmds_left = 20;
    run_until_idle("post-flush");

    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== source/operand_queue_top.sv ====
// Operand queue top: command FIFO, operand buffer, widening unit, output control
`timescale 1ns/1ns
`include "opq_settings.svh"

module operand_queue_top import opq_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         flush_i,
  // Command input from the operand requester
  input  opq_conv_e                    cmd_conv_i,
  input  opq_eew_e                     cmd_eew_i,
  input  opq_elem_cnt_t                cmd_elem_count_i,
  input  opq_target_e                  cmd_target_i,
  input  logic                         cmd_valid_i,
  output logic                         cmd_ready_o,
  // Register file side
  input  opq_word_t                    operand_i,
  input  logic                         operand_valid_i,
  input  logic                         operand_issued_i,
  output logic                         operand_queue_ready_o,
  // Consumer side
  output opq_word_t                    operand_o,
  output opq_target_e                  operand_target_o,
  output logic                         operand_valid_o,
  input  logic [`OPQ_NR_CONSUMERS-1:0] operand_ready_i
);

  opq_feed_if feed ();

  opq_cmd_t   cmd_in;
  logic       cmd_full;
  logic       cmd_empty;
  logic [2:0] slot;

  ////////////////////////////////////////////////////////////////////////////
  // Command buffer

  assign cmd_in = '{
    conv:       cmd_conv_i,
    eew:        cmd_eew_i,
    elem_count: cmd_elem_count_i,
    target:     cmd_target_i
  };

  assign cmd_ready_o    = ~cmd_full;
  assign feed.cmd_valid = ~cmd_empty;

  opq_fifo #(
    .DEPTH  (`OPQ_CMD_DEPTH),
    .DATA_T (opq_cmd_t)
  ) i_cmd_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (flush_i),
    .data_i  (cmd_in),
    .push_i  (cmd_valid_i & cmd_ready_o),
    .data_o  (feed.cmd),
    .pop_i   (feed.cmd_pop),
    .full_o  (cmd_full),
    .empty_o (cmd_empty)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Operand buffer, conversion and output

  opq_operand_buffer i_operand_buffer (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .operand_i             (operand_i),
    .operand_valid_i       (operand_valid_i),
    .operand_issued_i      (operand_issued_i),
    .operand_queue_ready_o (operand_queue_ready_o),
    .feed                  (feed)
  );

  opq_widen_unit i_widen_unit (
    .operand_i (feed.operand),
    .eew_i     (feed.cmd.eew),
    .conv_i    (feed.cmd.conv),
    .slot_i    (slot),
    .operand_o (operand_o)
  );

  opq_output_ctrl i_output_ctrl (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .flush_i          (flush_i),
    .feed             (feed),
    .operand_ready_i  (operand_ready_i),
    .slot_o           (slot),
    .operand_valid_o  (operand_valid_o),
    .operand_target_o (operand_target_o)
  );

endmodule

// ==== source/opq_feed_if.sv ====
// Feed interface from the command and operand buffers to the output control
`timescale 1ns/1ns

interface opq_feed_if import opq_pkg::*; ();

  // Command FIFO head
  opq_cmd_t  cmd;
  logic      cmd_valid;
  logic      cmd_pop;

  // Operand FIFO head
  opq_word_t operand;
  logic      operand_valid;
  logic      operand_pop;

  modport cmd_src (
    output cmd, cmd_valid,
    input  cmd_pop
  );

  modport data_src (
    output operand, operand_valid,
    input  operand_pop
  );

  modport sink (
    input  cmd, cmd_valid, operand, operand_valid,
    output cmd_pop, operand_pop
  );

endinterface

// ==== source/opq_fifo.sv ====
// Generic first-word-visible FIFO with flush
`timescale 1ns/1ns

module opq_fifo #(
  parameter int unsigned DEPTH  = 2,
  parameter type         DATA_T = logic
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  flush_i,
  input  DATA_T data_i,
  input  logic  push_i,
  output DATA_T data_o,
  input  logic  pop_i,
  output logic  full_o,
  output logic  empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  DATA_T            mem_q [DEPTH];
  logic [PTR_W-1:0] rd_ptr_q, wr_ptr_q;
  logic [CNT_W-1:0] usage_q;
  logic             do_push, do_pop;

  // Pointer increment with wrap at the last entry
  function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o  = (usage_q == CNT_W'(DEPTH));
  assign empty_o = (usage_q == '0);
  assign data_o  = mem_q[rd_ptr_q];
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      usage_q  <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (do_pop) rd_ptr_q <= next_ptr(rd_ptr_q);
      usage_q <= usage_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  // Storage array
  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= data_i;
  end

endmodule

// ==== source/opq_operand_buffer.sv ====
// Operand buffer: operand FIFO with the credit counter for issued reads
`timescale 1ns/1ns
`include "opq_settings.svh"

module opq_operand_buffer import opq_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            flush_i,
  input  opq_word_t       operand_i,
  input  logic            operand_valid_i,
  input  logic            operand_issued_i,
  output logic            operand_queue_ready_o,
  opq_feed_if.data_src    feed
);

  localparam int unsigned CREDIT_W = $clog2(`OPQ_DATA_DEPTH + 1);

  logic                empty;
  logic [CREDIT_W-1:0] credit_d, credit_q;

  opq_fifo #(
    .DEPTH  (`OPQ_DATA_DEPTH),
    .DATA_T (opq_word_t)
  ) i_data_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (flush_i),
    .data_i  (operand_i),
    .push_i  (operand_valid_i),
    .data_o  (feed.operand),
    .pop_i   (feed.operand_pop),
    .full_o  (),
    .empty_o (empty)
  );

  assign feed.operand_valid = ~empty;

  // Reads in flight plus words held, so every issued read has a free slot
  always_comb begin
    credit_d = credit_q;
    if (operand_issued_i) credit_d = credit_d + 1'b1;
    if (feed.operand_pop) credit_d = credit_d - 1'b1;
    if (flush_i) credit_d = '0;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) credit_q <= '0;
    else         credit_q <= credit_d;
  end

  assign operand_queue_ready_o = (credit_q < CREDIT_W'(`OPQ_DATA_DEPTH));

endmodule

// ==== source/opq_output_ctrl.sv ====
// Output control: element counter, source slot pointer and buffer pops
`timescale 1ns/1ns
`include "opq_settings.svh"

module opq_output_ctrl import opq_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         flush_i,
  opq_feed_if.sink                     feed,
  input  logic [`OPQ_NR_CONSUMERS-1:0] operand_ready_i,
  output logic [2:0]                   slot_o,
  output logic                         operand_valid_o,
  output opq_target_e                  operand_target_o
);

  localparam int unsigned CNT_W = `OPQ_ELEM_CNT_W;

  logic [2:0]    slot_d, slot_q;
  opq_elem_cnt_t count_d, count_q;
  logic          transfer;
  int unsigned   step_log;
  logic [3:0]    slot_sum;
  logic [3:0]    slots_per_word;
  logic [CNT_W:0] count_sum;
  logic          word_done;
  logic          cmd_done;

  assign operand_valid_o  = feed.cmd_valid & feed.operand_valid;
  assign operand_target_o = feed.cmd.target;
  assign slot_o           = slot_q;
  assign transfer         = operand_valid_o & (|operand_ready_i);

  ////////////////////////////////////////////////////////////////////////////
  // Advance per output word

  // Source elements consumed by one output word, log2
  assign step_log = OPQ_WORD_BYTES_LOG - int'(feed.cmd.eew)
                    - opq_factor_log(feed.cmd.eew, feed.cmd.conv);

  assign slots_per_word = 4'(1 << (OPQ_WORD_BYTES_LOG - int'(feed.cmd.eew)));
  assign slot_sum       = {1'b0, slot_q} + 4'(1 << step_log);
  assign word_done      = (slot_sum >= slots_per_word);

  assign count_sum = {1'b0, count_q} + (CNT_W + 1)'(1 << step_log);
  assign cmd_done  = (count_sum >= {1'b0, feed.cmd.elem_count});

  ////////////////////////////////////////////////////////////////////////////
  // Pop decisions and next state

  always_comb begin
    slot_d           = slot_q;
    count_d          = count_q;
    feed.cmd_pop     = 1'b0;
    feed.operand_pop = 1'b0;

    if (transfer) begin
      slot_d           = word_done ? 3'd0 : slot_sum[2:0];
      count_d          = count_sum[CNT_W-1:0];
      feed.operand_pop = word_done || (feed.cmd.conv == CONV_NONE);

      // Last elements of the command, the next one starts on a fresh word
      if (cmd_done) begin
        feed.operand_pop = 1'b1;
        feed.cmd_pop     = 1'b1;
        slot_d           = '0;
        count_d          = '0;
      end
    end

    if (flush_i) begin
      slot_d  = '0;
      count_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_q  <= '0;
      count_q <= '0;
    end else begin
      slot_q  <= slot_d;
      count_q <= count_d;
    end
  end

endmodule

// ==== source/opq_pkg.sv ====
// Operand queue types and conversion helper functions
`include "opq_settings.svh"

package opq_pkg;

  // Log2 of the number of bytes in one operand word
  localparam int unsigned OPQ_WORD_BYTES_LOG = $clog2(`OPQ_DATA_W / 8);

  typedef logic [`OPQ_DATA_W-1:0]     opq_word_t;
  typedef logic [`OPQ_ELEM_CNT_W-1:0] opq_elem_cnt_t;

  // Source element width, encoded as log2 of the byte count
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } opq_eew_e;

  typedef enum logic [2:0] {
    CONV_NONE  = 3'd0,
    CONV_SEXT2 = 3'd1,
    CONV_ZEXT2 = 3'd2,
    CONV_SEXT4 = 3'd3,
    CONV_ZEXT4 = 3'd4,
    CONV_SEXT8 = 3'd5,
    CONV_ZEXT8 = 3'd6
  } opq_conv_e;

  typedef enum logic {
    FU_ALU  = 1'b0,
    FU_MFPU = 1'b1
  } opq_target_e;

  typedef struct packed {
    opq_conv_e     conv;
    opq_eew_e      eew;
    opq_elem_cnt_t elem_count;
    opq_target_e   target;
  } opq_cmd_t;

  // Log2 of the widening factor
  // Pairs whose widened element exceeds a word behave as pass-through
  function automatic int unsigned opq_factor_log(opq_eew_e eew, opq_conv_e conv);
    int unsigned flog;
    case (conv)
      CONV_SEXT2, CONV_ZEXT2: flog = 1;
      CONV_SEXT4, CONV_ZEXT4: flog = 2;
      CONV_SEXT8, CONV_ZEXT8: flog = 3;
      default:                flog = 0;
    endcase
    if (int'(eew) + flog > OPQ_WORD_BYTES_LOG) flog = 0;
    return flog;
  endfunction

  function automatic logic opq_conv_signed(opq_conv_e conv);
    return conv inside {CONV_SEXT2, CONV_SEXT4, CONV_SEXT8};
  endfunction

endpackage

// ==== source/opq_widen_unit.sv ====
// Widening unit with sign or zero extension of packed elements from a source slot
`timescale 1ns/1ns

module opq_widen_unit import opq_pkg::*; (
  input  opq_word_t  operand_i,
  input  opq_eew_e   eew_i,
  input  opq_conv_e  conv_i,
  input  logic [2:0] slot_i,
  output opq_word_t  operand_o
);

  localparam int unsigned DATA_W = $bits(opq_word_t);
  localparam int unsigned IDX_W  = $clog2(DATA_W);

  int unsigned flog;
  logic        sext;

  assign flog = opq_factor_log(eew_i, conv_i);
  assign sext = opq_conv_signed(conv_i);

  // Result bit b lies in widened element e = b / (w*F) and comes from source element slot + e
  always_comb begin : p_widen
    int unsigned      in_sh;
    int unsigned      out_sh;
    int unsigned      elem;
    int unsigned      pos;
    logic [IDX_W-1:0] src;

    // Log2 of the element width in bits
    in_sh     = 3 + int'(eew_i);
    out_sh    = in_sh + flog;
    elem      = 0;
    pos       = 0;
    src       = '0;
    operand_o = operand_i;

    if (flog != 0) begin
      for (int b = 0; b < DATA_W; b++) begin
        elem = b >> out_sh;
        pos  = b & ((1 << out_sh) - 1);
        if (pos < (1 << in_sh)) begin
          src          = IDX_W'(((slot_i + elem) << in_sh) + pos);
          operand_o[b] = operand_i[src];
        end else begin
          // Extension bits copy the MSB of the source element
          src          = IDX_W'(((slot_i + elem) << in_sh) + (1 << in_sh) - 1);
          operand_o[b] = sext & operand_i[src];
        end
      end
    end
  end

endmodule
